// ==== include/cache_settings.svh ====
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Address and word widths
`define CACHE_ADDR_W 32
`define CACHE_DATA_W 32

// Address split is tag | index | byte offset within a line
`define CACHE_OFFSET_BITS 4
`define CACHE_INDEX_BITS 4
`define CACHE_TAG_BITS 24

// Geometry
`define CACHE_LINES 16
`define CACHE_WORDS_PER_LINE 4

`endif

// ==== design/cache_addr_pkg.sv ====
`default_nettype none

`include "cache_settings.svh"

package cache_addr_pkg;

  typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
  typedef logic [`CACHE_INDEX_BITS-1:0] index_t;
  typedef logic [$clog2(`CACHE_WORDS_PER_LINE)-1:0] word_sel_t;
  typedef logic [`CACHE_DATA_W-1:0] word_t;
  typedef logic [`CACHE_DATA_W/8-1:0] strb_t;
  typedef word_t [`CACHE_WORDS_PER_LINE-1:0] line_t;

  typedef struct packed {
    logic valid;
    logic dirty;
  } line_meta_t;

  // Byte address as seen by the cache
  typedef struct packed {
    tag_t tag;
    index_t index;
    word_sel_t word_sel;
    logic [`CACHE_OFFSET_BITS-$clog2(`CACHE_WORDS_PER_LINE)-1:0] byte_off;
  } addr_parts_t;

endpackage

`default_nettype wire

// ==== design/cache_ctrl_pkg.sv ====
`default_nettype none

`include "cache_settings.svh"

package cache_ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP_READ,
    LOOKUP_WRITE,
    WRITEBACK,
    DUMPING
  } cache_state_t;

  // Effective state once the lookup result is known
  typedef enum logic [2:0] {
    K_NONE,
    K_READ_HIT,
    K_READ_MISS,
    K_WRITE_HIT,
    K_WRITE_MISS
  } lookup_kind_t;

  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0] addr;
    cache_addr_pkg::word_t data;
    cache_addr_pkg::strb_t strb;
  } wr_req_t;

  // Whole-line transfer to or from backing memory
  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0] base;
    logic write;
    cache_addr_pkg::line_t line;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== design/line_store.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_settings.svh"

module line_store (
  input wire logic clk,

  input wire cache_addr_pkg::index_t rd_index,
  output cache_addr_pkg::line_t rd_line,

  input wire cache_addr_pkg::index_t wr_index,
  input wire logic [`CACHE_WORDS_PER_LINE-1:0] wr_en,
  input wire cache_addr_pkg::line_t wr_line
);

  // One block RAM per word position so single words can be written
  for (genvar w = 0; w < `CACHE_WORDS_PER_LINE; w++) begin : g_word
    cache_addr_pkg::word_t ram [`CACHE_LINES];
    cache_addr_pkg::word_t rd_word;

    // Read before write on a shared index
    always_ff @(posedge clk) begin
      rd_word <= ram[rd_index];
      if (wr_en[w]) begin
        ram[wr_index] <= wr_line[w];
      end
    end

    assign rd_line[w] = rd_word;
  end

endmodule

`default_nettype wire

// ==== design/tag_store.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_settings.svh"

module tag_store (
  input wire logic clk,
  input wire logic rst,

  input wire logic lookup_en,
  input wire cache_addr_pkg::addr_parts_t lookup_addr,

  input wire logic fill_en,
  input wire cache_addr_pkg::index_t fill_index,
  input wire cache_addr_pkg::tag_t fill_tag,
  input wire logic fill_dirty,

  input wire logic mark_dirty_en,
  input wire cache_addr_pkg::index_t mark_dirty_index,

  input wire cache_addr_pkg::index_t victim_index,
  input wire logic victim_capture,
  input wire logic invalidate_all,

  output logic hit,
  output cache_addr_pkg::tag_t stored_tag,
  output cache_addr_pkg::line_meta_t stored_meta
);

  cache_addr_pkg::tag_t tags [`CACHE_LINES];
  cache_addr_pkg::line_meta_t meta [`CACHE_LINES];
  cache_addr_pkg::tag_t req_tag;

  always_ff @(posedge clk) begin
    if (fill_en) begin
      tags[fill_index] <= fill_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || invalidate_all) begin
      for (int i = 0; i < `CACHE_LINES; i++) begin
        meta[i] <= '0;
      end
    end else begin
      if (fill_en) begin
        meta[fill_index] <= '{valid: 1'b1, dirty: fill_dirty};
      end
      if (mark_dirty_en) begin
        meta[mark_dirty_index].dirty <= 1'b1;
      end
    end
  end

  // Registered entry for the current request or the flush walk
  always_ff @(posedge clk) begin
    if (lookup_en) begin
      stored_tag <= tags[lookup_addr.index];
      req_tag <= lookup_addr.tag;
    end else if (victim_capture) begin
      stored_tag <= tags[victim_index];
    end else if (fill_en) begin
      stored_tag <= fill_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stored_meta <= '0;
    end else if (lookup_en) begin
      stored_meta <= meta[lookup_addr.index];
    end else if (victim_capture) begin
      stored_meta <= meta[victim_index];
    end else if (fill_en) begin
      stored_meta <= '{valid: 1'b1, dirty: fill_dirty};
    end
  end

  assign hit = stored_meta.valid && (stored_tag == req_tag);

  a_fill_vs_inval: assert property (@(posedge clk) disable iff (rst)
    !(fill_en && invalidate_all));

  a_dirty_valid: assert property (@(posedge clk) disable iff (rst)
    mark_dirty_en |-> meta[mark_dirty_index].valid);

endmodule

`default_nettype wire

// ==== design/cache_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_settings.svh"

module cache_fsm (
  input wire logic clk,
  input wire logic rst,

  input wire logic ar_valid,
  input wire cache_ctrl_pkg::rd_req_t rd_req,
  output logic ar_ready,
  input wire logic aw_valid,
  input wire cache_ctrl_pkg::wr_req_t wr_req,
  output logic aw_ready,
  output logic r_valid,
  output cache_addr_pkg::word_t r_data,
  input wire logic r_ready,
  output logic b_valid,
  input wire logic b_ready,

  output logic mem_req_valid,
  output cache_ctrl_pkg::mem_req_t mem_req,
  input wire logic mem_req_ready,
  input wire logic mem_resp_valid,
  input wire cache_addr_pkg::line_t mem_resp_line,

  input wire logic dump,
  output logic dumping,

  output cache_addr_pkg::index_t rd_index,
  output cache_addr_pkg::index_t wr_index,
  output logic [`CACHE_WORDS_PER_LINE-1:0] wr_en,
  output cache_addr_pkg::line_t wr_line,
  output logic lookup_en,
  output cache_addr_pkg::addr_parts_t lookup_addr,
  output logic fill_en,
  output cache_addr_pkg::index_t fill_index,
  output cache_addr_pkg::tag_t fill_tag,
  output logic fill_dirty,
  output logic mark_dirty_en,
  output cache_addr_pkg::index_t mark_dirty_index,
  output cache_addr_pkg::index_t victim_index,
  output logic victim_capture,
  output logic invalidate_all,

  input wire cache_addr_pkg::line_t rd_line,
  input wire logic hit,
  input wire cache_addr_pkg::tag_t stored_tag,
  input wire cache_addr_pkg::line_meta_t stored_meta
);

  localparam logic [`CACHE_INDEX_BITS:0] DUMP_END = `CACHE_LINES;

  cache_ctrl_pkg::cache_state_t state;
  cache_ctrl_pkg::cache_state_t state_nxt;
  cache_ctrl_pkg::lookup_kind_t kind;

  cache_addr_pkg::addr_parts_t req_parts;
  cache_addr_pkg::addr_parts_t acc_parts;
  cache_addr_pkg::word_t req_data;
  cache_addr_pkg::strb_t req_strb;
  cache_addr_pkg::line_t line_q;
  cache_addr_pkg::line_t cur_line;
  cache_addr_pkg::word_t cur_word;
  cache_addr_pkg::word_t merged_word;

  logic use_fill;
  logic req_sent;
  logic wr_done;
  logic wb_pend;
  logic dump_chk;
  logic [`CACHE_INDEX_BITS:0] dump_cnt;

  logic miss;
  logic resp_done;
  logic accept;
  logic store_wr;
  logic fill_now;
  logic flush_done;

  always_comb begin
    case (state)
      cache_ctrl_pkg::LOOKUP_READ:
        kind = hit ? cache_ctrl_pkg::K_READ_HIT : cache_ctrl_pkg::K_READ_MISS;
      cache_ctrl_pkg::LOOKUP_WRITE:
        kind = hit ? cache_ctrl_pkg::K_WRITE_HIT : cache_ctrl_pkg::K_WRITE_MISS;
      default: kind = cache_ctrl_pkg::K_NONE;
    endcase
  end

  assign miss = (kind == cache_ctrl_pkg::K_READ_MISS) || (kind == cache_ctrl_pkg::K_WRITE_MISS);
  // Store update only on the first b_valid cycle
  assign store_wr = (kind == cache_ctrl_pkg::K_WRITE_HIT) && !wr_done;
  assign fill_now = miss && req_sent && mem_resp_valid;
  assign flush_done = (state == cache_ctrl_pkg::DUMPING) && !dump_chk && (dump_cnt == DUMP_END);

  always_comb begin
    case (kind)
      cache_ctrl_pkg::K_READ_HIT: resp_done = r_ready;
      cache_ctrl_pkg::K_WRITE_HIT: resp_done = b_ready;
      default: resp_done = (state == cache_ctrl_pkg::IDLE);
    endcase
  end

  // No accept while the RAM write of a write hit is in flight
  assign ar_ready = resp_done && !wb_pend && !dump && !dumping && !store_wr;
  assign aw_ready = ar_ready && aw_valid;
  assign accept = aw_ready || (ar_valid && ar_ready);
  assign acc_parts = aw_ready ? wr_req.addr : rd_req.addr;

  always_comb begin
    state_nxt = state;
    case (state)
      cache_ctrl_pkg::WRITEBACK: begin
        if (mem_req_ready) begin
          state_nxt = (dumping || dump) ? cache_ctrl_pkg::DUMPING : cache_ctrl_pkg::IDLE;
        end
      end
      cache_ctrl_pkg::DUMPING: begin
        if (flush_done) begin
          state_nxt = cache_ctrl_pkg::IDLE;
        end else if (dump_chk && stored_meta.valid && stored_meta.dirty) begin
          state_nxt = cache_ctrl_pkg::WRITEBACK;
        end
      end
      default: begin
        if (resp_done) begin
          if (wb_pend) begin
            state_nxt = cache_ctrl_pkg::WRITEBACK;
          end else if (dump || dumping) begin
            state_nxt = cache_ctrl_pkg::DUMPING;
          end else if (aw_ready) begin
            state_nxt = cache_ctrl_pkg::LOOKUP_WRITE;
          end else if (accept) begin
            state_nxt = cache_ctrl_pkg::LOOKUP_READ;
          end else begin
            state_nxt = cache_ctrl_pkg::IDLE;
          end
        end
      end
    endcase
  end

  // Hit word comes from the fill register right after a miss
  always_comb begin
    cur_line = use_fill ? line_q : rd_line;
    cur_word = cur_line[req_parts.word_sel];
    for (int b = 0; b < `CACHE_DATA_W / 8; b++) begin
      merged_word[b*8+:8] = req_strb[b] ? req_data[b*8+:8] : cur_word[b*8+:8];
    end
  end

  assign r_valid = (kind == cache_ctrl_pkg::K_READ_HIT);
  assign b_valid = (kind == cache_ctrl_pkg::K_WRITE_HIT);
  assign r_data = cur_word;
  assign mem_req_valid = (miss && !req_sent) || (state == cache_ctrl_pkg::WRITEBACK);

  always_comb begin
    if (state == cache_ctrl_pkg::DUMPING) begin
      rd_index = dump_cnt[`CACHE_INDEX_BITS-1:0];
    end else begin
      rd_index = accept ? acc_parts.index : req_parts.index;
    end
    wr_en = '0;
    if (fill_now) begin
      wr_en = '1;
    end else if (store_wr) begin
      wr_en[req_parts.word_sel] = 1'b1;
    end
    wr_line = fill_now ? mem_resp_line : {`CACHE_WORDS_PER_LINE{merged_word}};
  end

  assign wr_index = req_parts.index;
  assign lookup_en = accept;
  assign lookup_addr = acc_parts;
  assign fill_en = fill_now;
  assign fill_index = req_parts.index;
  assign fill_tag = req_parts.tag;
  assign fill_dirty = (state == cache_ctrl_pkg::LOOKUP_WRITE);
  assign mark_dirty_en = store_wr;
  assign mark_dirty_index = req_parts.index;
  assign victim_index = dump_cnt[`CACHE_INDEX_BITS-1:0];
  assign victim_capture = (state == cache_ctrl_pkg::DUMPING) && !dump_chk && !flush_done;
  assign invalidate_all = flush_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cache_ctrl_pkg::IDLE;
      use_fill <= 1'b0;
      req_sent <= 1'b0;
      wr_done <= 1'b0;
      wb_pend <= 1'b0;
      dump_chk <= 1'b0;
      dump_cnt <= '0;
      dumping <= 1'b0;
    end else begin
      state <= state_nxt;
      dumping <= (dumping || dump) && !flush_done;
      if (accept) begin
        use_fill <= 1'b0;
        req_sent <= 1'b0;
        wr_done <= 1'b0;
      end
      if (miss && mem_req_valid && mem_req_ready) begin
        req_sent <= 1'b1;
      end
      if (fill_now) begin
        use_fill <= 1'b1;
        wb_pend <= stored_meta.valid && stored_meta.dirty;
      end
      if (store_wr) begin
        wr_done <= 1'b1;
      end
      if ((state == cache_ctrl_pkg::WRITEBACK) && mem_req_ready) begin
        wb_pend <= 1'b0;
      end
      // Flush walk alternates capture and check per line
      if (state == cache_ctrl_pkg::DUMPING) begin
        if (flush_done) begin
          dump_cnt <= '0;
        end else if (!dump_chk) begin
          dump_chk <= 1'b1;
        end else begin
          dump_chk <= 1'b0;
          dump_cnt <= dump_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_parts <= acc_parts;
      req_data <= wr_req.data;
      req_strb <= wr_req.strb;
      mem_req.base <= {acc_parts.tag, acc_parts.index, {`CACHE_OFFSET_BITS{1'b0}}};
      mem_req.write <= 1'b0;
    end
    // Victim line is still on rd_line during the fill cycle
    if (fill_now) begin
      line_q <= mem_resp_line;
      mem_req.base <= {stored_tag, req_parts.index, {`CACHE_OFFSET_BITS{1'b0}}};
      mem_req.write <= 1'b1;
      mem_req.line <= rd_line;
    end
    if ((state == cache_ctrl_pkg::DUMPING) && dump_chk) begin
      mem_req.base <= {stored_tag, victim_index, {`CACHE_OFFSET_BITS{1'b0}}};
      mem_req.write <= 1'b1;
      mem_req.line <= rd_line;
    end
  end

  a_resp_excl: assert property (@(posedge clk) disable iff (rst)
    !(r_valid && b_valid));

  a_mem_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

  a_no_accept_dump: assert property (@(posedge clk) disable iff (rst)
    dumping |-> !ar_ready);

endmodule

`default_nettype wire

// ==== design/bram_cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_settings.svh"

module bram_cache_top (
  input wire logic clk,
  input wire logic rst,

  input wire logic ar_valid,
  input wire cache_ctrl_pkg::rd_req_t rd_req,
  output logic ar_ready,
  input wire logic aw_valid,
  input wire cache_ctrl_pkg::wr_req_t wr_req,
  output logic aw_ready,
  output logic r_valid,
  output cache_addr_pkg::word_t r_data,
  input wire logic r_ready,
  output logic b_valid,
  input wire logic b_ready,

  output logic mem_req_valid,
  output cache_ctrl_pkg::mem_req_t mem_req,
  input wire logic mem_req_ready,
  input wire logic mem_resp_valid,
  input wire cache_addr_pkg::line_t mem_resp_line,

  input wire logic dump,
  output logic dumping
);

  cache_addr_pkg::index_t rd_index;
  cache_addr_pkg::index_t wr_index;
  logic [`CACHE_WORDS_PER_LINE-1:0] wr_en;
  cache_addr_pkg::line_t wr_line;
  cache_addr_pkg::line_t rd_line;

  logic lookup_en;
  cache_addr_pkg::addr_parts_t lookup_addr;
  logic fill_en;
  cache_addr_pkg::index_t fill_index;
  cache_addr_pkg::tag_t fill_tag;
  logic fill_dirty;
  logic mark_dirty_en;
  cache_addr_pkg::index_t mark_dirty_index;
  cache_addr_pkg::index_t victim_index;
  logic victim_capture;
  logic invalidate_all;
  logic hit;
  cache_addr_pkg::tag_t stored_tag;
  cache_addr_pkg::line_meta_t stored_meta;

  // Lookup stage
  line_store u_line_store (
    .clk      (clk),
    .rd_index (rd_index),
    .rd_line  (rd_line),
    .wr_index (wr_index),
    .wr_en    (wr_en),
    .wr_line  (wr_line)
  );

  tag_store u_tag_store (
    .clk              (clk),
    .rst              (rst),
    .lookup_en        (lookup_en),
    .lookup_addr      (lookup_addr),
    .fill_en          (fill_en),
    .fill_index       (fill_index),
    .fill_tag         (fill_tag),
    .fill_dirty       (fill_dirty),
    .mark_dirty_en    (mark_dirty_en),
    .mark_dirty_index (mark_dirty_index),
    .victim_index     (victim_index),
    .victim_capture   (victim_capture),
    .invalidate_all   (invalidate_all),
    .hit              (hit),
    .stored_tag       (stored_tag),
    .stored_meta      (stored_meta)
  );

  // Resolve stage
  cache_fsm u_cache_fsm (
    .clk              (clk),
    .rst              (rst),
    .ar_valid         (ar_valid),
    .rd_req           (rd_req),
    .ar_ready         (ar_ready),
    .aw_valid         (aw_valid),
    .wr_req           (wr_req),
    .aw_ready         (aw_ready),
    .r_valid          (r_valid),
    .r_data           (r_data),
    .r_ready          (r_ready),
    .b_valid          (b_valid),
    .b_ready          (b_ready),
    .mem_req_valid    (mem_req_valid),
    .mem_req          (mem_req),
    .mem_req_ready    (mem_req_ready),
    .mem_resp_valid   (mem_resp_valid),
    .mem_resp_line    (mem_resp_line),
    .dump             (dump),
    .dumping          (dumping),
    .rd_index         (rd_index),
    .wr_index         (wr_index),
    .wr_en            (wr_en),
    .wr_line          (wr_line),
    .lookup_en        (lookup_en),
    .lookup_addr      (lookup_addr),
    .fill_en          (fill_en),
    .fill_index       (fill_index),
    .fill_tag         (fill_tag),
    .fill_dirty       (fill_dirty),
    .mark_dirty_en    (mark_dirty_en),
    .mark_dirty_index (mark_dirty_index),
    .victim_index     (victim_index),
    .victim_capture   (victim_capture),
    .invalidate_all   (invalidate_all),
    .rd_line          (rd_line),
    .hit              (hit),
    .stored_tag       (stored_tag),
    .stored_meta      (stored_meta)
  );

endmodule

`default_nettype wire

// ==== tb/cache_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_checker (
  input wire logic clk,
  input wire logic rst,
  input wire logic ar_valid,
  input wire cache_ctrl_pkg::rd_req_t rd_req,
  input wire logic ar_ready,
  input wire logic aw_valid,
  input wire cache_ctrl_pkg::wr_req_t wr_req,
  input wire logic aw_ready,
  input wire logic r_valid,
  input wire cache_addr_pkg::word_t r_data,
  input wire logic r_ready,
  input wire logic b_valid,
  input wire logic b_ready,
  input wire logic mem_req_valid,
  input wire cache_ctrl_pkg::mem_req_t mem_req,
  input wire logic mem_req_ready,
  input wire logic dumping,
  input wire cache_addr_pkg::word_t exp_data,
  output int error_count,
  output int check_count
);

  // Expected contents of every word across cache and memory
  cache_addr_pkg::word_t ref_words [logic [31:0]];
  // Lines that must still be written back
  bit dirty_set [logic [31:0]];

  logic res_valid [16];
  logic [23:0] res_tag [16];
  logic res_dirty [16];

  logic [31:0] cur_addr;
  logic [31:0] cur_base;
  logic exp_reads;
  int rd_cnt;
  logic evict_owed;
  logic [31:0] evict_base;
  logic dumping_q;

  initial begin
    error_count = 0;
    check_count = 0;
  end

  function automatic cache_addr_pkg::word_t ref_word(input logic [31:0] addr);
    if (ref_words.exists(addr)) begin
      return ref_words[addr];
    end
    return ~addr;
  endfunction

  task automatic report_error(input string msg);
    error_count++;
    $display("error %0t: %s", $time, msg);
  endtask

  task automatic accept_req(input logic [31:0] addr, input logic is_write,
                            input logic [31:0] data, input logic [3:0] strb);
    logic [3:0] idx;
    logic [23:0] tg;
    logic miss;
    cache_addr_pkg::word_t w;
    idx = addr[7:4];
    tg = addr[31:8];
    if (evict_owed) begin
      report_error($sformatf("dirty victim 0x%08h not written back", evict_base));
      evict_owed = 1'b0;
    end
    miss = !(res_valid[idx] && res_tag[idx] == tg);
    if (miss && res_valid[idx] && res_dirty[idx]) begin
      evict_owed = 1'b1;
      evict_base = {res_tag[idx], idx, 4'h0};
    end
    if (miss) begin
      res_valid[idx] = 1'b1;
      res_tag[idx] = tg;
      res_dirty[idx] = 1'b0;
    end
    cur_addr = {addr[31:2], 2'b00};
    cur_base = {addr[31:4], 4'h0};
    exp_reads = miss;
    rd_cnt = 0;
    if (is_write) begin
      res_dirty[idx] = 1'b1;
      dirty_set[cur_base] = 1'b1;
      w = ref_word(cur_addr);
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          w[b*8+:8] = data[b*8+:8];
        end
      end
      ref_words[cur_addr] = w;
    end
  endtask

  task automatic compare_mem_req();
    check_count++;
    if (!mem_req.write) begin
      if (!exp_reads || rd_cnt != 0) begin
        report_error($sformatf("unexpected line read at 0x%08h", mem_req.base));
      end else if (mem_req.base != cur_base) begin
        report_error($sformatf("line read at 0x%08h, expected 0x%08h",
                               mem_req.base, cur_base));
      end
      rd_cnt++;
    end else if (!dirty_set.exists(mem_req.base)) begin
      report_error($sformatf("write-back of clean line 0x%08h", mem_req.base));
    end else begin
      for (int w = 0; w < 4; w++) begin
        if (mem_req.line[w] != ref_word(mem_req.base + 4 * w)) begin
          report_error($sformatf("write-back word 0x%08h is 0x%08h, expected 0x%08h",
                                 mem_req.base + 4 * w, mem_req.line[w],
                                 ref_word(mem_req.base + 4 * w)));
        end
      end
      dirty_set.delete(mem_req.base);
      if (evict_owed && mem_req.base == evict_base) begin
        evict_owed = 1'b0;
      end
    end
  endtask

  task automatic verify_response(input logic is_read);
    check_count++;
    if (rd_cnt != int'(exp_reads)) begin
      report_error($sformatf("access 0x%08h made %0d line reads, expected %0d",
                             cur_addr, rd_cnt, exp_reads));
    end
    if (is_read && (r_data != ref_word(cur_addr) || r_data != exp_data)) begin
      report_error($sformatf("read 0x%08h returned 0x%08h, model 0x%08h, file 0x%08h",
                             cur_addr, r_data, ref_word(cur_addr), exp_data));
    end
  endtask

  // Once a flush is done nothing dirty may remain and the cache is empty
  task automatic close_flush();
    check_count++;
    if (dirty_set.num() != 0 || evict_owed) begin
      report_error($sformatf("%0d dirty lines left after flush", dirty_set.num()));
      dirty_set.delete();
      evict_owed = 1'b0;
    end
    for (int i = 0; i < 16; i++) begin
      res_valid[i] = 1'b0;
      res_dirty[i] = 1'b0;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        res_valid[i] = 1'b0;
        res_dirty[i] = 1'b0;
        res_tag[i] = '0;
      end
      exp_reads = 1'b0;
      rd_cnt = 0;
      evict_owed = 1'b0;
      dumping_q = 1'b0;
    end else begin
      if (aw_valid && aw_ready) begin
        accept_req(wr_req.addr, 1'b1, wr_req.data, wr_req.strb);
      end else if (ar_valid && ar_ready) begin
        accept_req(rd_req.addr, 1'b0, '0, '0);
      end
      if (mem_req_valid && mem_req_ready) begin
        compare_mem_req();
      end
      if (r_valid && r_ready) begin
        verify_response(1'b1);
      end
      if (b_valid && b_ready) begin
        verify_response(1'b0);
      end
      if (dumping_q && !dumping) begin
        close_flush();
      end
      dumping_q = dumping;
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_top;

  logic clk;
  logic rst;
  logic ar_valid;
  cache_ctrl_pkg::rd_req_t rd_req;
  logic ar_ready;
  logic aw_valid;
  cache_ctrl_pkg::wr_req_t wr_req;
  logic aw_ready;
  logic r_valid;
  cache_addr_pkg::word_t r_data;
  logic r_ready;
  logic b_valid;
  logic b_ready;
  logic mem_req_valid;
  cache_ctrl_pkg::mem_req_t mem_req;
  logic mem_req_ready;
  logic mem_resp_valid;
  cache_addr_pkg::line_t mem_resp_line;
  logic dump;
  logic dumping;

  cache_addr_pkg::word_t exp_data;
  int error_count;
  int check_count;
  int seed = 32'hc3d;

  // One entry per operation of the data file
  string op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [3:0] strb_q[$];
  logic [31:0] exp_q[$];
  int n_ops;
  logic loaded;

  // Sparse backing memory where unwritten words hold the inverted address
  cache_addr_pkg::word_t mem_words [logic [31:0]];

  bram_cache_top uut (
    .clk            (clk),
    .rst            (rst),
    .ar_valid       (ar_valid),
    .rd_req         (rd_req),
    .ar_ready       (ar_ready),
    .aw_valid       (aw_valid),
    .wr_req         (wr_req),
    .aw_ready       (aw_ready),
    .r_valid        (r_valid),
    .r_data         (r_data),
    .r_ready        (r_ready),
    .b_valid        (b_valid),
    .b_ready        (b_ready),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_req_ready  (mem_req_ready),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_line  (mem_resp_line),
    .dump           (dump),
    .dumping        (dumping)
  );

  cache_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .ar_valid      (ar_valid),
    .rd_req        (rd_req),
    .ar_ready      (ar_ready),
    .aw_valid      (aw_valid),
    .wr_req        (wr_req),
    .aw_ready      (aw_ready),
    .r_valid       (r_valid),
    .r_data        (r_data),
    .r_ready       (r_ready),
    .b_valid       (b_valid),
    .b_ready       (b_ready),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .dumping       (dumping),
    .exp_data      (exp_data),
    .error_count   (error_count),
    .check_count   (check_count)
  );

  initial begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;

  function automatic cache_addr_pkg::word_t mem_word(input logic [31:0] addr);
    if (mem_words.exists(addr)) begin
      return mem_words[addr];
    end
    return ~addr;
  endfunction

  task automatic load_tests();
    int fd;
    int n;
    string text;
    string op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    logic [3:0] s;
    fd = $fopen("tb/cache_tests.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        n = $fgets(text, fd);
        if (n > 1 && text.substr(0, 0) != "#") begin
          n = $sscanf(text, "%s %h %h %h %h", op, a, d, s, e);
          if (n == 5) begin
            op_q.push_back(op);
            addr_q.push_back(a);
            data_q.push_back(d);
            strb_q.push_back(s);
            exp_q.push_back(e);
          end
        end
      end
      $fclose(fd);
      n_ops = op_q.size();
      loaded = 1'b1;
    end
  endtask

  // Read with an optional stall on r_ready before the response is taken
  task automatic read_word(input logic [31:0] addr, input logic [31:0] exp, input logic stall);
    int wait_cycles;
    exp_data <= exp;
    rd_req <= '{addr: addr};
    ar_valid <= 1'b1;
    r_ready <= !stall;
    do @(posedge clk); while (!ar_ready);
    ar_valid <= 1'b0;
    if (stall) begin
      do @(posedge clk); while (!r_valid);
      wait_cycles = ($unsigned($random(seed)) % 4) + 1;
      repeat (wait_cycles) @(posedge clk);
      r_ready <= 1'b1;
    end
    do @(posedge clk); while (!(r_valid && r_ready));
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    wr_req <= '{addr: addr, data: data, strb: strb};
    aw_valid <= 1'b1;
    do @(posedge clk); while (!aw_ready);
    aw_valid <= 1'b0;
    do @(posedge clk); while (!(b_valid && b_ready));
  endtask

  task automatic flush_cache();
    dump <= 1'b1;
    @(posedge clk);
    dump <= 1'b0;
    do @(posedge clk); while (!dumping);
    do @(posedge clk); while (dumping);
  endtask

  // Line memory that takes requests after a random delay
  initial begin : mem_model
    cache_ctrl_pkg::mem_req_t req;
    cache_addr_pkg::line_t line;
    int delay;
    forever begin
      @(posedge clk);
      if (!rst && mem_req_valid) begin
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge clk);
        req = mem_req;
        mem_req_ready <= 1'b1;
        @(posedge clk);
        mem_req_ready <= 1'b0;
        if (req.write) begin
          for (int w = 0; w < 4; w++) begin
            mem_words[req.base + 4 * w] = req.line[w];
          end
        end else begin
          for (int w = 0; w < 4; w++) begin
            line[w] = mem_word(req.base + 4 * w);
          end
          repeat (2) @(posedge clk);
          mem_resp_line <= line;
          mem_resp_valid <= 1'b1;
          @(posedge clk);
          mem_resp_valid <= 1'b0;
        end
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (n_ops * 200) @(posedge clk);
    $display("timeout: the operations did not complete within %0d cycles", n_ops * 200);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    rst = 1'b1;
    ar_valid = 1'b0;
    rd_req = '0;
    aw_valid = 1'b0;
    wr_req = '0;
    r_ready = 1'b1;
    b_ready = 1'b1;
    mem_req_ready = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_line = '0;
    dump = 1'b0;
    exp_data = '0;
    loaded = 1'b0;
    n_ops = 0;
    load_tests();
    if (!loaded) begin
      $display("could not open the test file tb/cache_tests.txt");
      $display("TEST FAILED");
      $finish;
    end else begin
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      for (int i = 0; i < n_ops; i++) begin
        case (op_q[i])
          "R": read_word(addr_q[i], exp_q[i], 1'b0);
          "S": read_word(addr_q[i], exp_q[i], 1'b1);
          "W": write_word(addr_q[i], data_q[i], strb_q[i]);
          "D": flush_cache();
          default: $display("unknown opcode %s in the test file, skipped", op_q[i]);
        endcase
      end
      repeat (5) @(posedge clk);
      $display("operations=%0d checks=%0d errors=%0d", n_ops, check_count, error_count);
      if (error_count == 0 && n_ops > 0) begin
        $display("TEST PASSED");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tb/cache_tests.txt ====
# op addr data strb expected ; R read, S read with r_ready stall, W write, D dump
# unread memory words hold the bitwise inverse of their byte address
R 00000000 00000000 0 ffffffff
R 00000004 00000000 0 fffffffb
W 00000008 11223344 f 00000000
R 00000008 00000000 0 11223344
W 0000000c aabbccdd 5 00000000
R 0000000c 00000000 0 ffbbffdd
S 00000010 00000000 0 ffffffef
R 00000100 00000000 0 fffffeff
R 00000000 00000000 0 ffffffff
R 00000008 00000000 0 11223344
W 00000024 55667788 c 00000000
W 00000230 cafef00d 3 00000000
D 00000000 00000000 0 00000000
R 00000024 00000000 0 5566ffdb
D 00000000 00000000 0 00000000
R 00000230 00000000 0 fffff00d
S 00000234 00000000 0 fffffdcb
W 00000000 01020304 2 00000000
R 00001000 00000000 0 ffffefff
R 00000000 00000000 0 ffff03ff
D 00000000 00000000 0 00000000
D 00000000 00000000 0 00000000

// ==== tb.f ====
+incdir+include
design/cache_addr_pkg.sv
design/cache_ctrl_pkg.sv
design/line_store.sv
design/tag_store.sv
design/cache_fsm.sv
design/bram_cache_top.sv
tb/cache_checker.sv
tb/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_top -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
